/* all.f */
+incdir+logic
logic/socket_route_pkg.sv
logic/socket_bus_pkg.sv
logic/socket_req_arb.sv
logic/socket_rsp_router.sv
logic/socket_busy_tracker.sv
logic/socket_interconnect.sv
logic/socket_tb_mem.sv
test/socket_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the socket interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module socket_tb -f all.f -o socket_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/socket_sim > sim.log 2>&1

grep -q "TEST RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* test/socket_tb.sv */
// Socket interconnect testbench
// Table-driven fetch and data traffic against a memory model, plus
// arbitration order, back-pressure and busy checks

`timescale 1ns/10ps
`default_nettype none

`include "socket_defines.svh"

module socket_tb;

    localparam int TABLE_LEN = 9;

    typedef struct packed {
        logic [1:0]  core;
        logic        fetch;
        logic        rw;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  tag;
        logic [31:0] exp;
    } entry_t;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic hold_req = 1'b0;
    socket_bus_pkg::fetch_req_t [3:0] fetch_req = '0;
    logic [3:0] fetch_req_valid = '0;
    wire  [3:0] fetch_req_ready;
    socket_bus_pkg::data_req_t [3:0] data_req = '0;
    logic [3:0] data_req_valid = '0;
    wire  [3:0] data_req_ready;
    socket_bus_pkg::core_rsp_t [3:0] fetch_rsp;
    wire  [3:0] fetch_rsp_valid;
    logic [3:0] fetch_rsp_ready = '1;
    socket_bus_pkg::core_rsp_t [3:0] data_rsp;
    wire  [3:0] data_rsp_valid;
    logic [3:0] data_rsp_ready = '1;
    logic [3:0] core_busy = '0;
    socket_bus_pkg::mem_req_t mem_req;
    wire  mem_req_valid;
    wire  mem_req_ready;
    socket_bus_pkg::mem_rsp_t mem_rsp;
    wire  mem_rsp_valid;
    wire  mem_rsp_ready;
    wire  busy;

    entry_t table_q [TABLE_LEN];
    int f_pend [4];
    int d_pend [4];
    int hold_left;
    int cb_left;
    int rsp_hold_left;
    int out_cnt;
    int stall_seen;
    int blocked;
    int errors;
    int tests;
    socket_route_pkg::mem_tag_t grant_q [$];
    int rsp_core [$];
    logic rsp_fetch [$];
    logic [31:0] rsp_data [$];
    logic [3:0] rsp_tag [$];

    socket_interconnect dut_i (.*);

    socket_tb_mem mem_i (.*);

    always #50 clk = ~clk;

    initial begin
        #(TABLE_LEN * 200 * 100);
        $display("Watchdog expired before the tests completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic report(input string msg);
        $display("FAIL @%0t: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    // Controls and request valids for the coming cycle
    task automatic apply_controls();
        hold_req = (hold_left > 0);
        if (hold_left > 0) hold_left--;
        core_busy = (cb_left > 0) ? 4'b0100 : 4'b0000;
        if (cb_left > 0) cb_left--;
        fetch_rsp_ready = (rsp_hold_left > 0) ? 4'b1011 : 4'b1111;
        if (rsp_hold_left > 0) rsp_hold_left--;
        for (int i = 0; i < 4; i++) begin
            fetch_req_valid[i] = (f_pend[i] > 0);
            data_req_valid[i]  = (d_pend[i] > 0);
        end
    endtask

    // Runs the clock until n_rsp responses have been taken, checking as it goes
    task automatic pump(input int n_rsp);
        int got;
        int cycles;
        logic exp_busy;
        logic have_exp;
        logic was_stalled;
        logic [3:0] f_acc;
        logic [3:0] d_acc;
        socket_bus_pkg::mem_req_t snap;
        got = 0;
        cycles = 0;
        have_exp = 1'b0;
        was_stalled = 1'b0;
        snap = '0;
        exp_busy = 1'b0;
        grant_q.delete();
        rsp_core.delete();
        rsp_fetch.delete();
        rsp_data.delete();
        rsp_tag.delete();
        stall_seen = 0;
        blocked = 0;
        apply_controls();
        while (got < n_rsp && cycles < 400) begin
            @(negedge clk);
            cycles++;
            if (was_stalled && (mem_req !== snap || !mem_req_valid)) report("mem_req moved in stall");
            was_stalled = mem_req_valid && !mem_req_ready;
            if (was_stalled) begin
                snap = mem_req;
                stall_seen++;
                if (|fetch_req_ready || |data_req_ready) report("core ready during stall");
            end
            if (have_exp && busy !== exp_busy) report("busy does not match outstanding state");
            exp_busy = (out_cnt != 0) || (|core_busy);
            have_exp = 1'b1;
            if (mem_req_valid && mem_req_ready) begin
                grant_q.push_back(mem_req.tag);
                out_cnt++;
            end
            if ($countones({fetch_rsp_valid, data_rsp_valid}) > 1) begin
                report("response on two channels");
            end
            for (int i = 0; i < 4; i++) begin
                if (fetch_rsp_valid[i] || data_rsp_valid[i]) begin
                    if (mem_rsp_ready !== (fetch_rsp_valid[i] ? fetch_rsp_ready[i]
                                                               : data_rsp_ready[i])) begin
                        report("mem_rsp_ready differs from core ready");
                    end
                    if (mem_rsp_ready) begin
                        rsp_core.push_back(i);
                        rsp_fetch.push_back(fetch_rsp_valid[i]);
                        rsp_data.push_back(fetch_rsp_valid[i] ? fetch_rsp[i].data
                                                              : data_rsp[i].data);
                        rsp_tag.push_back(fetch_rsp_valid[i] ? fetch_rsp[i].tag : data_rsp[i].tag);
                        got++;
                        out_cnt--;
                    end else begin
                        blocked++;
                    end
                end
            end
            f_acc = fetch_req_valid & fetch_req_ready;
            d_acc = data_req_valid & data_req_ready;
            @(posedge clk);
            #5;
            for (int i = 0; i < 4; i++) begin
                if (f_acc[i]) begin
                    f_pend[i]--;
                    fetch_req[i].tag  = fetch_req[i].tag + 4'd1;
                    fetch_req[i].addr = fetch_req[i].addr + 32'd4;
                end
                if (d_acc[i]) begin
                    d_pend[i]--;
                end
            end
            apply_controls();
        end
        if (got < n_rsp) begin
            $display("Timed out waiting for memory responses");
            errors++;
        end
    endtask

    initial begin
        int e0;
        logic [3:0] seen;
        table_q[0] = '{2'd0, 1'b1, 1'b0, 32'h0000_1000, 32'h0, 4'h1, ~32'h0000_1000};
        table_q[1] = '{2'd1, 1'b1, 1'b0, 32'h0000_1004, 32'h0, 4'h2, ~32'h0000_1004};
        table_q[2] = '{2'd2, 1'b1, 1'b0, 32'h0000_2008, 32'h0, 4'h3, ~32'h0000_2008};
        table_q[3] = '{2'd3, 1'b1, 1'b0, 32'h0000_300c, 32'h0, 4'h4, ~32'h0000_300c};
        table_q[4] = '{2'd0, 1'b0, 1'b1, 32'h0000_4000, 32'hcafe_0001, 4'h5, 32'h0};
        table_q[5] = '{2'd2, 1'b0, 1'b0, 32'h0000_4000, 32'h0, 4'h6, 32'hcafe_0001};
        table_q[6] = '{2'd3, 1'b0, 1'b1, 32'h0000_5000, 32'h1234_5678, 4'h7, 32'h0};
        table_q[7] = '{2'd1, 1'b0, 1'b0, 32'h0000_5000, 32'h0, 4'h8, 32'h1234_5678};
        table_q[8] = '{2'd1, 1'b1, 1'b0, 32'h0000_5000, 32'h0, 4'h9, 32'h1234_5678};
        errors = 0;
        tests = 0;
        out_cnt = 0;
        hold_left = 0;
        cb_left = 0;
        rsp_hold_left = 0;
        for (int i = 0; i < 4; i++) begin
            f_pend[i] = 0;
            d_pend[i] = 0;
        end
        repeat (16) @(posedge clk);
        #5 reset = 1'b0;
        @(negedge clk);
        if (mem_req_valid || |fetch_req_ready || |data_req_ready || busy) begin
            report("outputs not idle after reset");
        end
        @(posedge clk);
        #5;

        ////////////////////////////////////////////////
        // Table of single requests
        ////////////////////////////////////////////////
        for (int t = 0; t < TABLE_LEN; t++) begin
            e0 = errors;
            if (table_q[t].fetch) begin
                fetch_req[table_q[t].core] = '{table_q[t].addr, table_q[t].tag};
                f_pend[table_q[t].core] = 1;
            end else begin
                data_req[table_q[t].core] = '{table_q[t].rw, table_q[t].addr,
                                              table_q[t].wdata, table_q[t].tag};
                d_pend[table_q[t].core] = 1;
            end
            pump(1);
            if (rsp_core.size() == 1) begin
                if (rsp_core[0] != int'(table_q[t].core)
                    || rsp_fetch[0] != table_q[t].fetch) begin
                    report("response on wrong channel");
                end
                if (rsp_tag[0] !== table_q[t].tag) report("response tag mismatch");
                if (!table_q[t].rw && rsp_data[0] !== table_q[t].exp) report("read data mismatch");
            end
            end_test($sformatf("table_%0d", t), e0);
        end

        // Fetch and data together, fetch first
        e0 = errors;
        fetch_req[1] = '{32'h0000_6000, 4'ha};
        data_req[2] = '{1'b0, 32'h0000_6100, 32'h0, 4'hb};
        f_pend[1] = 1;
        d_pend[2] = 1;
        pump(2);
        if (grant_q.size() != 2 || !grant_q[0].is_fetch || grant_q[1].is_fetch) begin
            report("fetch not granted first");
        end
        end_test("fetch_priority", e0);

        // Round robin among four fetching cores
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            fetch_req[i] = '{32'h0000_7000 + 32'(i * 16'h100), 4'h0};
            f_pend[i] = 2;
        end
        pump(8);
        if (grant_q.size() != 8) report("fetch grant count wrong");
        for (int w = 0; w + 4 <= grant_q.size(); w++) begin
            seen = '0;
            for (int k = 0; k < 4; k++) begin
                seen[grant_q[w + k].core_id] = 1'b1;
            end
            if (seen != 4'b1111) report("four grants repeat a core");
        end
        end_test("round_robin", e0);

        // Memory back-pressure, then core back-pressure
        e0 = errors;
        hold_left = 10;
        fetch_req[0] = '{32'h0000_8000, 4'h3};
        data_req[3] = '{1'b1, 32'h0000_8004, 32'h5a5a_0003, 4'h4};
        f_pend[0] = 1;
        d_pend[3] = 1;
        pump(2);
        if (stall_seen < 8) report("memory stall not observed");
        if (rsp_core.size() != 2 || rsp_core[0] != 0 || rsp_tag[0] !== 4'h3
            || rsp_core[1] != 3 || rsp_tag[1] !== 4'h4) begin
            report("request lost under stall");
        end
        rsp_hold_left = 8;
        fetch_req[2] = '{32'h0000_9000, 4'h6};
        f_pend[2] = 1;
        pump(1);
        if (blocked == 0) report("core back-pressure never held memory");
        end_test("back_pressure", e0);

        // Busy follows outstanding work and core busy
        e0 = errors;
        cb_left = 6;
        data_req[3] = '{1'b0, 32'h0000_8004, 32'h0, 4'h7};
        d_pend[3] = 1;
        pump(1);
        if (rsp_data.size() == 1 && rsp_data[0] !== 32'h5a5a_0003) report("read data mismatch");
        cb_left = 0;
        core_busy = '0;
        repeat (3) @(negedge clk);
        if (busy !== 1'b0) report("busy stuck high when idle");
        end_test("busy", e0);

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/socket_tb_mem.sv */
// Memory model for the socket testbench
// Stores writes, answers reads with the stored word or the inverted
// address, and returns responses in order after 0 to 3 cycles

`timescale 1ns/10ps
`default_nettype none

`include "socket_defines.svh"

module socket_tb_mem (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            hold_req,
    input  wire socket_bus_pkg::mem_req_t  mem_req,
    input  wire                            mem_req_valid,
    output logic                           mem_req_ready,
    output socket_bus_pkg::mem_rsp_t       mem_rsp,
    output logic                           mem_rsp_valid,
    input  wire                            mem_rsp_ready
);

    logic [`SOCKET_DATA_W-1:0] store [logic [`SOCKET_ADDR_W-1:0]];
    socket_bus_pkg::mem_rsp_t  rsp_q [$];
    logic [31:0]               lcg_state;
    int                        wait_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign mem_req_ready = !hold_req;

    always @(posedge clk) begin
        socket_bus_pkg::mem_rsp_t r;
        if (reset) begin
            mem_rsp_valid <= 1'b0;
            mem_rsp       <= '0;
            rsp_q.delete();
            lcg_state     = 32'he7eb;
            wait_cnt      = 0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                r.tag = mem_req.tag;
                if (mem_req.rw) begin
                    store[mem_req.addr] = mem_req.data;
                    r.data = '0;
                end else if (store.exists(mem_req.addr)) begin
                    r.data = store[mem_req.addr];
                end else begin
                    r.data = ~mem_req.addr;
                end
                rsp_q.push_back(r);
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                mem_rsp_valid <= 1'b0;
                void'(rsp_q.pop_front());
                lcg_state = lcg_next(lcg_state);
                wait_cnt  = int'(lcg_state[17:16]);
            end else if (!mem_rsp_valid && rsp_q.size() > 0) begin
                if (wait_cnt == 0) begin
                    mem_rsp       <= rsp_q[0];
                    mem_rsp_valid <= 1'b1;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/socket_interconnect.sv */
// Socket memory interconnect
// Fetch and data ports of every core share one memory port;
// responses return by tag, and busy covers cores and memory

`timescale 1ns/10ps
`default_nettype none

`include "socket_defines.svh"

module socket_interconnect (
    input  wire                                                 clk,
    input  wire                                                 reset,

    input  wire socket_bus_pkg::fetch_req_t [`SOCKET_SIZE-1:0]  fetch_req,
    input  wire [`SOCKET_SIZE-1:0]                              fetch_req_valid,
    output logic [`SOCKET_SIZE-1:0]                             fetch_req_ready,
    input  wire socket_bus_pkg::data_req_t [`SOCKET_SIZE-1:0]   data_req,
    input  wire [`SOCKET_SIZE-1:0]                              data_req_valid,
    output logic [`SOCKET_SIZE-1:0]                             data_req_ready,

    output socket_bus_pkg::core_rsp_t [`SOCKET_SIZE-1:0]        fetch_rsp,
    output logic [`SOCKET_SIZE-1:0]                             fetch_rsp_valid,
    input  wire [`SOCKET_SIZE-1:0]                              fetch_rsp_ready,
    output socket_bus_pkg::core_rsp_t [`SOCKET_SIZE-1:0]        data_rsp,
    output logic [`SOCKET_SIZE-1:0]                             data_rsp_valid,
    input  wire [`SOCKET_SIZE-1:0]                              data_rsp_ready,

    input  wire [`SOCKET_SIZE-1:0]                              core_busy,

    output socket_bus_pkg::mem_req_t                            mem_req,
    output logic                                                mem_req_valid,
    input  wire                                                 mem_req_ready,
    input  wire socket_bus_pkg::mem_rsp_t                       mem_rsp,
    input  wire                                                 mem_rsp_valid,
    output logic                                                mem_rsp_ready,

    output logic                                                busy
);

    logic mem_req_fire;
    logic mem_rsp_fire;

    assign mem_req_fire = mem_req_valid && mem_req_ready;
    assign mem_rsp_fire = mem_rsp_valid && mem_rsp_ready;

    socket_req_arb req_arb_i (
        .clk             (clk),
        .reset           (reset),
        .fetch_req       (fetch_req),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .data_req        (data_req),
        .data_req_valid  (data_req_valid),
        .data_req_ready  (data_req_ready),
        .mem_req         (mem_req),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready)
    );

    socket_rsp_router rsp_router_i (
        .mem_rsp         (mem_rsp),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_ready   (mem_rsp_ready),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_rsp        (data_rsp),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp_ready  (data_rsp_ready)
    );

    socket_busy_tracker busy_tracker_i (
        .clk       (clk),
        .reset     (reset),
        .req_fire  (mem_req_fire),
        .rsp_fire  (mem_rsp_fire),
        .core_busy (core_busy),
        .busy      (busy)
    );

endmodule

`default_nettype wire

/* logic/socket_busy_tracker.sv */
// Socket busy tracker
// Counts memory requests still awaiting a response and registers
// socket busy from that count and the per-core busy flags

`timescale 1ns/10ps
`default_nettype none

`include "socket_defines.svh"

module socket_busy_tracker (
    input  wire                    clk,
    input  wire                    reset,

    input  wire                    req_fire,
    input  wire                    rsp_fire,
    input  wire [`SOCKET_SIZE-1:0] core_busy,

    output logic                   busy
);

    localparam int CNT_W = 8;

    logic [CNT_W-1:0] count;

    //////////////////////////////////////////////////
    // Outstanding count
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({req_fire, rsp_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= (count != '0) || (|core_busy);
        end
    end

    // Memory may only answer what the arbiter already issued
    no_orphan_rsp_a: assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> (count != '0))
        else $error("memory response with nothing outstanding");

endmodule

`default_nettype wire

/* logic/socket_rsp_router.sv */
// Socket response router
// Sends each memory response to the core and class named in its tag,
// and passes that channel's ready back to memory

`timescale 1ns/10ps
`default_nettype none

`include "socket_defines.svh"

module socket_rsp_router (
    input  wire socket_bus_pkg::mem_rsp_t                mem_rsp,
    input  wire                                          mem_rsp_valid,
    output logic                                         mem_rsp_ready,

    output socket_bus_pkg::core_rsp_t [`SOCKET_SIZE-1:0] fetch_rsp,
    output logic [`SOCKET_SIZE-1:0]                      fetch_rsp_valid,
    input  wire [`SOCKET_SIZE-1:0]                       fetch_rsp_ready,

    output socket_bus_pkg::core_rsp_t [`SOCKET_SIZE-1:0] data_rsp,
    output logic [`SOCKET_SIZE-1:0]                      data_rsp_valid,
    input  wire [`SOCKET_SIZE-1:0]                       data_rsp_ready
);

    socket_route_pkg::mem_tag_t tag;
    socket_bus_pkg::core_rsp_t  rsp;

    assign tag = mem_rsp.tag;

    // Tag stripped back to what the core issued
    assign rsp.data = mem_rsp.data;
    assign rsp.tag  = tag.core_tag;

    //////////////////////////////////////////////////
    // Per-core steering
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `SOCKET_SIZE; i++) begin
            fetch_rsp[i]       = rsp;
            data_rsp[i]        = rsp;
            fetch_rsp_valid[i] = mem_rsp_valid && tag.is_fetch
                              && (tag.core_id == socket_route_pkg::core_id_t'(i));
            data_rsp_valid[i]  = mem_rsp_valid && !tag.is_fetch
                              && (tag.core_id == socket_route_pkg::core_id_t'(i));
        end
    end

    // Selected core holds memory off
    assign mem_rsp_ready = tag.is_fetch ? fetch_rsp_ready[tag.core_id]
                                        : data_rsp_ready[tag.core_id];

endmodule

`default_nettype wire

/* logic/socket_req_arb.sv */
// Socket request arbiter
// Round robin among cores within each class, fetch ahead of data,
// into one registered memory request slot

`timescale 1ns/10ps
`default_nettype none

`include "socket_defines.svh"

module socket_req_arb (
    input  wire                                          clk,
    input  wire                                          reset,

    input  wire socket_bus_pkg::fetch_req_t [`SOCKET_SIZE-1:0] fetch_req,
    input  wire [`SOCKET_SIZE-1:0]                       fetch_req_valid,
    output logic [`SOCKET_SIZE-1:0]                      fetch_req_ready,

    input  wire socket_bus_pkg::data_req_t [`SOCKET_SIZE-1:0]  data_req,
    input  wire [`SOCKET_SIZE-1:0]                       data_req_valid,
    output logic [`SOCKET_SIZE-1:0]                      data_req_ready,

    output socket_bus_pkg::mem_req_t                     mem_req,
    output logic                                         mem_req_valid,
    input  wire                                          mem_req_ready
);

    socket_route_pkg::core_id_t fetch_ptr;
    socket_route_pkg::core_id_t data_ptr;
    socket_route_pkg::core_id_t fetch_pick;
    socket_route_pkg::core_id_t data_pick;
    logic                       any_fetch;
    logic                       any_data;
    logic                       can_load;
    logic                       grant;
    socket_bus_pkg::mem_req_t   mem_req_d;

    // First valid core at or after ptr, wrapping
    function automatic socket_route_pkg::core_id_t rr_pick(
        input logic [`SOCKET_SIZE-1:0] valid,
        input socket_route_pkg::core_id_t ptr
    );
        socket_route_pkg::core_id_t idx;
        socket_route_pkg::core_id_t pick;
        pick = ptr;
        for (int k = `SOCKET_SIZE - 1; k >= 0; k--) begin
            idx = socket_route_pkg::core_id_t'(ptr + socket_route_pkg::core_id_t'(k));
            if (valid[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

    assign any_fetch  = |fetch_req_valid;
    assign any_data   = |data_req_valid;
    assign fetch_pick = rr_pick(fetch_req_valid, fetch_ptr);
    assign data_pick  = rr_pick(data_req_valid, data_ptr);

    // Slot empty or draining this edge
    assign can_load = !mem_req_valid || mem_req_ready;
    assign grant    = can_load && (any_fetch || any_data);

    always_comb begin
        for (int i = 0; i < `SOCKET_SIZE; i++) begin
            fetch_req_ready[i] = can_load && any_fetch
                              && (fetch_pick == socket_route_pkg::core_id_t'(i));
            data_req_ready[i]  = can_load && !any_fetch && any_data
                              && (data_pick == socket_route_pkg::core_id_t'(i));
        end
    end

    //////////////////////////////////////////////////
    // Tagged request build
    //////////////////////////////////////////////////

    always_comb begin
        if (any_fetch) begin
            mem_req_d.rw           = 1'b0;
            mem_req_d.addr         = fetch_req[fetch_pick].addr;
            mem_req_d.data         = '0;
            mem_req_d.tag.is_fetch = 1'b1;
            mem_req_d.tag.core_id  = fetch_pick;
            mem_req_d.tag.core_tag = fetch_req[fetch_pick].tag;
        end else begin
            mem_req_d.rw           = data_req[data_pick].rw;
            mem_req_d.addr         = data_req[data_pick].addr;
            mem_req_d.data         = data_req[data_pick].data;
            mem_req_d.tag.is_fetch = 1'b0;
            mem_req_d.tag.core_id  = data_pick;
            mem_req_d.tag.core_tag = data_req[data_pick].tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_req_valid <= 1'b0;
            fetch_ptr     <= '0;
            data_ptr      <= '0;
        end else begin
            if (can_load) begin
                mem_req_valid <= any_fetch || any_data;
            end
            if (grant && any_fetch) begin
                fetch_ptr <= socket_route_pkg::core_id_t'(fetch_pick + 1'b1);
            end
            if (grant && !any_fetch) begin
                data_ptr <= socket_route_pkg::core_id_t'(data_pick + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            mem_req <= mem_req_d;
        end
    end

    // Stalled request must not change under the memory
    stall_hold_a: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req changed while stalled");

endmodule

`default_nettype wire

/* logic/socket_bus_pkg.sv */
// Socket bus payloads
// Core-side fetch and data requests, core responses, and the
// single memory-side request and response

`default_nettype none

`include "socket_defines.svh"

package socket_bus_pkg;

    typedef struct packed {
        logic [`SOCKET_ADDR_W-1:0]     addr;
        logic [`SOCKET_CORE_TAG_W-1:0] tag;
    } fetch_req_t;

    typedef struct packed {
        logic                          rw;
        logic [`SOCKET_ADDR_W-1:0]     addr;
        logic [`SOCKET_DATA_W-1:0]     data;
        logic [`SOCKET_CORE_TAG_W-1:0] tag;
    } data_req_t;

    typedef struct packed {
        logic [`SOCKET_DATA_W-1:0]     data;
        logic [`SOCKET_CORE_TAG_W-1:0] tag;
    } core_rsp_t;

    // Memory side, tagged with origin
    typedef struct packed {
        logic                          rw;
        logic [`SOCKET_ADDR_W-1:0]     addr;
        logic [`SOCKET_DATA_W-1:0]     data;
        socket_route_pkg::mem_tag_t    tag;
    } mem_req_t;

    typedef struct packed {
        logic [`SOCKET_DATA_W-1:0]     data;
        socket_route_pkg::mem_tag_t    tag;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* logic/socket_route_pkg.sv */
// Socket routing types
// Core index and the memory tag that carries a request's origin
// out to memory and back again

`default_nettype none

`include "socket_defines.svh"

package socket_route_pkg;

    //////////////////////////////////////////////////
    // Core index
    //////////////////////////////////////////////////

    typedef logic [`SOCKET_CORE_ID_W-1:0] core_id_t;

    //////////////////////////////////////////////////
    // Memory tag
    //////////////////////////////////////////////////

    // Class, issuing core and the core's own tag
    typedef struct packed {
        logic                          is_fetch;
        core_id_t                      core_id;
        logic [`SOCKET_CORE_TAG_W-1:0] core_tag;
    } mem_tag_t;

endpackage

`default_nettype wire

/* logic/socket_defines.svh */
// Socket interconnect sizing
// Core count and the widths of addresses, data and tags on both sides

`ifndef SOCKET_DEFINES_SVH
`define SOCKET_DEFINES_SVH

//////////////////////////////////////////////////
// Socket geometry
//////////////////////////////////////////////////

// Cores sharing the memory port
`define SOCKET_SIZE        4

// Must cover SOCKET_SIZE
`define SOCKET_CORE_ID_W   2

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

`define SOCKET_ADDR_W      32

`define SOCKET_DATA_W      32

// Tag as issued by a core, returned unchanged
`define SOCKET_CORE_TAG_W  4

`endif
